// ==== logic/neander_address_unit.sv ====
`timescale 1ns/100ps

module neander_address_unit (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 rem_load,
    input  logic                 addr_sel_pc,
    input  logic                 rdm_load,
    input  logic                 ri_load,
    input  logic                 pc_inc,
    input  logic                 pc_load,
    input  neander_pkg::word_t   mem_data_in,
    output neander_pkg::addr_t   mem_addr,
    output neander_pkg::opcode_t opcode
);

    import neander_pkg::*;

    addr_t pc;
    addr_t rem;
    addr_t rem_next;
    word_t rdm;
    word_t ri;

    // Program counter, a load wins over an increment
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= RESET_PC;
        end else if (pc_load) begin
            pc <= rdm;
        end else if (pc_inc) begin
            pc <= pc + 1'b1;
        end
    end

    // Address source for REM
    assign rem_next = addr_sel_pc ? pc : rdm;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rem <= '0;
        end else if (rem_load) begin
            rem <= rem_next;
        end
    end

    // Memory read data capture
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rdm <= '0;
        end else if (rdm_load) begin
            rdm <= mem_data_in;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ri <= '0;
        end else if (ri_load) begin
            ri <= rdm;
        end
    end

    assign mem_addr = rem;
    assign opcode   = ri[7:4];

endmodule

// ==== logic/neander_cpu.sv ====
`timescale 1ns/100ps

module neander_cpu (
    input  logic               clk,
    input  logic               reset,
    input  neander_pkg::word_t mem_data_in,
    output neander_pkg::addr_t mem_addr,
    output neander_pkg::word_t mem_data_out,
    output logic               mem_write,
    output logic               halted
);

    import neander_pkg::*;

    // Control strobes from decode
    logic    rem_load;
    logic    addr_sel_pc;
    logic    rdm_load;
    logic    ri_load;
    logic    pc_inc;
    logic    pc_load;
    logic    ac_load;
    alu_op_t alu_op;

    // Status back to decode
    opcode_t opcode;
    logic    flag_n;
    logic    flag_z;

    neander_decode u_decode (
        .clk         (clk),
        .reset       (reset),
        .opcode      (opcode),
        .flag_n      (flag_n),
        .flag_z      (flag_z),
        .rem_load    (rem_load),
        .addr_sel_pc (addr_sel_pc),
        .rdm_load    (rdm_load),
        .ri_load     (ri_load),
        .pc_inc      (pc_inc),
        .pc_load     (pc_load),
        .ac_load     (ac_load),
        .alu_op      (alu_op),
        .mem_write   (mem_write),
        .halted      (halted)
    );

    neander_address_unit u_address_unit (
        .clk         (clk),
        .reset       (reset),
        .rem_load    (rem_load),
        .addr_sel_pc (addr_sel_pc),
        .rdm_load    (rdm_load),
        .ri_load     (ri_load),
        .pc_inc      (pc_inc),
        .pc_load     (pc_load),
        .mem_data_in (mem_data_in),
        .mem_addr    (mem_addr),
        .opcode      (opcode)
    );

    // Accumulator drives the store data
    neander_execute u_execute (
        .clk         (clk),
        .reset       (reset),
        .ac_load     (ac_load),
        .alu_op      (alu_op),
        .mem_data_in (mem_data_in),
        .ac          (mem_data_out),
        .flag_n      (flag_n),
        .flag_z      (flag_z)
    );

endmodule

// ==== logic/neander_decode.sv ====
`timescale 1ns/100ps

module neander_decode (
    input  logic                 clk,
    input  logic                 reset,
    input  neander_pkg::opcode_t opcode,
    input  logic                 flag_n,
    input  logic                 flag_z,
    output logic                 rem_load,
    output logic                 addr_sel_pc,
    output logic                 rdm_load,
    output logic                 ri_load,
    output logic                 pc_inc,
    output logic                 pc_load,
    output logic                 ac_load,
    output neander_pkg::alu_op_t alu_op,
    output logic                 mem_write,
    output logic                 halted
);

    import neander_pkg::*;

    // Memory-operand instructions share the OPER states,
    // jumps share the JUMP states
    typedef enum logic [3:0] {
        S_FETCH_1,
        S_FETCH_2,
        S_FETCH_3,
        S_DECODE,
        S_OPER_1,
        S_OPER_2,
        S_OPER_3,
        S_EXEC,
        S_NOT,
        S_JUMP_1,
        S_JUMP_2,
        S_JUMP_3,
        S_HALT
    } state_t;

    state_t state;
    state_t next_state;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= S_FETCH_1;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        rem_load    = 1'b0;
        addr_sel_pc = 1'b1;
        rdm_load    = 1'b0;
        ri_load     = 1'b0;
        pc_inc      = 1'b0;
        pc_load     = 1'b0;
        ac_load     = 1'b0;
        alu_op      = ALU_PASS;
        mem_write   = 1'b0;
        halted      = 1'b0;
        next_state  = state;

        case (state)
            // ----------------------------------------
            // Instruction fetch
            // ----------------------------------------
            S_FETCH_1: begin
                rem_load   = 1'b1;
                next_state = S_FETCH_2;
            end
            S_FETCH_2: begin
                rdm_load   = 1'b1;
                next_state = S_FETCH_3;
            end
            S_FETCH_3: begin
                ri_load    = 1'b1;
                pc_inc     = 1'b1;
                next_state = S_DECODE;
            end

            S_DECODE: begin
                case (opcode)
                    OP_STA, OP_LDA, OP_ADD, OP_OR, OP_AND: next_state = S_OPER_1;
                    OP_NOT:                                next_state = S_NOT;
                    OP_JMP, OP_JN, OP_JZ:                  next_state = S_JUMP_1;
                    OP_HLT:                                next_state = S_HALT;
                    // NOP and unused opcodes
                    default:                               next_state = S_FETCH_1;
                endcase
            end

            // ----------------------------------------
            // Operand address, then operand access
            // ----------------------------------------
            S_OPER_1: begin
                rem_load   = 1'b1;
                next_state = S_OPER_2;
            end
            S_OPER_2: begin
                rdm_load   = 1'b1;
                pc_inc     = 1'b1;
                next_state = S_OPER_3;
            end
            S_OPER_3: begin
                // Operand address held in RDM goes to REM
                addr_sel_pc = 1'b0;
                rem_load    = 1'b1;
                next_state  = S_EXEC;
            end
            S_EXEC: begin
                case (opcode)
                    OP_STA: mem_write = 1'b1;
                    OP_LDA: begin
                        ac_load = 1'b1;
                        alu_op  = ALU_PASS;
                    end
                    OP_ADD: begin
                        ac_load = 1'b1;
                        alu_op  = ALU_ADD;
                    end
                    OP_OR: begin
                        ac_load = 1'b1;
                        alu_op  = ALU_OR;
                    end
                    OP_AND: begin
                        ac_load = 1'b1;
                        alu_op  = ALU_AND;
                    end
                    default: ac_load = 1'b0;
                endcase
                next_state = S_FETCH_1;
            end

            S_NOT: begin
                ac_load    = 1'b1;
                alu_op     = ALU_NOT;
                next_state = S_FETCH_1;
            end

            // ----------------------------------------
            // Jumps
            // ----------------------------------------
            S_JUMP_1: begin
                rem_load   = 1'b1;
                next_state = S_JUMP_2;
            end
            S_JUMP_2: begin
                rdm_load   = 1'b1;
                next_state = S_JUMP_3;
            end
            S_JUMP_3: begin
                // Not taken skips the target byte
                case (opcode)
                    OP_JMP: pc_load = 1'b1;
                    OP_JN: begin
                        pc_load = flag_n;
                        pc_inc  = !flag_n;
                    end
                    OP_JZ: begin
                        pc_load = flag_z;
                        pc_inc  = !flag_z;
                    end
                    default: pc_inc = 1'b1;
                endcase
                next_state = S_FETCH_1;
            end

            // Left only by reset
            S_HALT: begin
                halted     = 1'b1;
                next_state = S_HALT;
            end

            default: next_state = S_FETCH_1;
        endcase
    end

endmodule

// ==== logic/neander_execute.sv ====
`timescale 1ns/100ps

module neander_execute (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 ac_load,
    input  neander_pkg::alu_op_t alu_op,
    input  neander_pkg::word_t   mem_data_in,
    output neander_pkg::word_t   ac,
    output logic                 flag_n,
    output logic                 flag_z
);

    import neander_pkg::*;

    word_t alu_result;

    // ----------------------------------------
    // ALU
    // ----------------------------------------
    always_comb begin
        case (alu_op)
            ALU_ADD:  alu_result = ac + mem_data_in;
            ALU_AND:  alu_result = ac & mem_data_in;
            ALU_OR:   alu_result = ac | mem_data_in;
            ALU_NOT:  alu_result = ~ac;
            ALU_PASS: alu_result = mem_data_in;
            // Unused codes hold the accumulator
            default:  alu_result = ac;
        endcase
    end

    // ----------------------------------------
    // Accumulator and flags
    // ----------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ac <= '0;
        end else if (ac_load) begin
            ac <= alu_result;
        end
    end

    // Flags follow the value written to AC
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            flag_n <= 1'b0;
            flag_z <= 1'b0;
        end else if (ac_load) begin
            flag_n <= alu_result[WORD_W-1];
            flag_z <= (alu_result == '0);
        end
    end

endmodule

// ==== logic/neander_pkg.sv ====
package neander_pkg;

    // ----------------------------------------
    // Widths and types
    // ----------------------------------------
    localparam int WORD_W = 8;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [WORD_W-1:0] addr_t;
    typedef logic [3:0]        opcode_t;
    typedef logic [2:0]        alu_op_t;

    // First fetch address after reset
    localparam addr_t RESET_PC = 8'h00;

    // ----------------------------------------
    // Instruction opcodes (upper nibble of RI)
    // ----------------------------------------
    localparam opcode_t OP_NOP = 4'h0;
    localparam opcode_t OP_STA = 4'h1;
    localparam opcode_t OP_LDA = 4'h2;
    localparam opcode_t OP_ADD = 4'h3;
    localparam opcode_t OP_OR  = 4'h4;
    localparam opcode_t OP_AND = 4'h5;
    localparam opcode_t OP_NOT = 4'h6;
    localparam opcode_t OP_JMP = 4'h8;
    localparam opcode_t OP_JN  = 4'h9;
    localparam opcode_t OP_JZ  = 4'hA;
    localparam opcode_t OP_HLT = 4'hF;

    // ----------------------------------------
    // ALU operations
    // ----------------------------------------
    localparam alu_op_t ALU_ADD  = 3'd0;
    localparam alu_op_t ALU_AND  = 3'd1;
    localparam alu_op_t ALU_OR   = 3'd2;
    // Invert the accumulator, memory word ignored
    localparam alu_op_t ALU_NOT  = 3'd3;
    // Memory word straight through, for LDA
    localparam alu_op_t ALU_PASS = 3'd4;

endpackage

// ==== neander_cpu.f ====
logic/neander_pkg.sv
logic/neander_decode.sv
logic/neander_address_unit.sv
logic/neander_execute.sv
logic/neander_cpu.sv
sim/neander_ram.sv
sim/neander_cpu_tb.sv

// ==== sim/neander_cpu_tb.sv ====
`timescale 1ns/100ps

module neander_cpu_tb;

    import neander_pkg::*;

    localparam int HALF_PERIOD  = 4;
    localparam int HALT_TIMEOUT = 2000;
    localparam int SEED         = 54985;

    // Data, result and marker locations, well clear of the programs
    localparam addr_t A_ADDR   = 8'h80;
    localparam addr_t B_ADDR   = 8'h81;
    localparam addr_t RES_ADDR = 8'h90;
    localparam addr_t AUX_ADDR = 8'h91;
    localparam addr_t MARK_N   = 8'hA0;
    localparam addr_t MARK_Z   = 8'hA1;
    localparam addr_t MARK_J   = 8'hA2;

    logic  clk;
    logic  reset;
    word_t mem_data_in;
    addr_t mem_addr;
    word_t mem_data_out;
    logic  mem_write;
    logic  halted;

    addr_t load_addr;
    word_t expected_mem [256];
    int    seed;

    neander_cpu u_neander_cpu (
        .clk          (clk),
        .reset        (reset),
        .mem_data_in  (mem_data_in),
        .mem_addr     (mem_addr),
        .mem_data_out (mem_data_out),
        .mem_write    (mem_write),
        .halted       (halted)
    );

    neander_ram u_ram (
        .clk        (clk),
        .addr       (mem_addr),
        .write_data (mem_data_out),
        .write_en   (mem_write),
        .read_data  (mem_data_in)
    );

    initial clk = 1'b0;
    always #HALF_PERIOD clk = ~clk;

    // ----------------------------------------
    // Failure reporting and checks
    // ----------------------------------------
    task automatic abort_run();
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_equal(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("Fail at %0t: %s expected %02h, got %02h", $time, name, expected, actual);
            abort_run();
        end
    endtask

    // ----------------------------------------
    // Program loading
    // ----------------------------------------
    // Every word starts from an address-dependent pattern
    task automatic begin_program();
        for (int i = 0; i < 256; i++) begin
            u_ram.mem[i] = word_t'(i) ^ 8'hC3;
        end
        load_addr = RESET_PC;
    endtask

    task automatic emit(input word_t value);
        u_ram.mem[load_addr] = value;
        load_addr = load_addr + 8'd1;
    endtask

    task automatic emit_single(input opcode_t op);
        emit({op, 4'h0});
    endtask

    task automatic emit_op(input opcode_t op, input addr_t operand);
        emit({op, 4'h0});
        emit(operand);
    endtask

    task automatic poke(input addr_t addr, input word_t value);
        u_ram.mem[addr] = value;
    endtask

    // ----------------------------------------
    // Reset and run control
    // ----------------------------------------
    task automatic apply_reset();
        @(posedge clk);
        reset <= 1'b1;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
    endtask

    task automatic wait_for_halt();
        int cycles;
        cycles = 0;
        while (halted !== 1'b1 && cycles < HALT_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (halted !== 1'b1) begin
            $display("Processor never halted within %0d cycles", HALT_TIMEOUT);
            abort_run();
        end
    endtask

    task automatic run_program();
        apply_reset();
        wait_for_halt();
    endtask

    // ----------------------------------------
    // Directed tests
    // ----------------------------------------
    task automatic test_load_store();
        word_t value;
        value = word_t'($urandom());
        begin_program();
        emit_op(OP_LDA, A_ADDR);
        emit_op(OP_STA, RES_ADDR);
        emit_single(OP_HLT);
        poke(A_ADDR, value);
        poke(RES_ADDR, ~value);
        run_program();
        check_equal("mem[RES] after STA", value, u_ram.mem[RES_ADDR]);
        check_equal("mem[A] source word", value, u_ram.mem[A_ADDR]);
    endtask

    // Runs after another program so REM and halted start nonzero
    task automatic test_reset_state();
        begin_program();
        emit_single(OP_HLT);
        apply_reset();
        @(negedge clk);
        check_equal("mem_write after reset", 8'h00, word_t'(mem_write));
        check_equal("halted after reset", 8'h00, word_t'(halted));
        check_equal("mem_addr after reset", 8'h00, mem_addr);
        // First fetch edge loads REM from the reset PC
        @(negedge clk);
        check_equal("mem_addr at first fetch", RESET_PC, mem_addr);
        wait_for_halt();
        check_equal("mem_write at halt", 8'h00, word_t'(mem_write));
    endtask

    task automatic run_alu_program(input opcode_t op, input word_t a, input word_t b,
                                   input word_t expected, input string name);
        begin_program();
        emit_op(OP_LDA, A_ADDR);
        if (op == OP_NOT) begin
            emit_single(OP_NOT);
        end else begin
            emit_op(op, B_ADDR);
        end
        emit_op(OP_STA, RES_ADDR);
        emit_single(OP_HLT);
        poke(A_ADDR, a);
        poke(B_ADDR, b);
        poke(RES_ADDR, ~expected);
        run_program();
        check_equal(name, expected, u_ram.mem[RES_ADDR]);
    endtask

    task automatic test_alu();
        word_t a;
        word_t b;
        int    sum;
        a = word_t'($urandom());
        b = word_t'($urandom());
        sum = (int'(a) + int'(b)) % 256;
        run_alu_program(OP_ADD, a, b, word_t'(sum), "ADD result");
        run_alu_program(OP_AND, a, b, a & b, "AND result");
        run_alu_program(OP_OR, a, b, a | b, "OR result");
        run_alu_program(OP_NOT, a, b, ~a, "NOT result");
        // Carry out of bit 7 is dropped
        run_alu_program(OP_ADD, 8'hFF, 8'h02, 8'h01, "ADD wrap result");
    endtask

    // Markers start as the inverted value, a store leaves the value itself
    task automatic run_jump_program(input word_t value);
        begin_program();
        emit_op(OP_LDA, A_ADDR);
        emit_op(OP_JN, load_addr + 8'd4);
        emit_op(OP_STA, MARK_N);
        emit_op(OP_JZ, load_addr + 8'd4);
        emit_op(OP_STA, MARK_Z);
        emit_op(OP_JMP, load_addr + 8'd4);
        emit_op(OP_STA, MARK_J);
        emit_single(OP_HLT);
        poke(A_ADDR, value);
        poke(MARK_N, ~value);
        poke(MARK_Z, ~value);
        poke(MARK_J, ~value);
        run_program();
        check_equal("marker after JN", value[7] ? ~value : value, u_ram.mem[MARK_N]);
        check_equal("marker after JZ", (value == 8'h00) ? ~value : value, u_ram.mem[MARK_Z]);
        check_equal("marker after JMP", ~value, u_ram.mem[MARK_J]);
    endtask

    task automatic test_jumps();
        word_t negative;
        word_t positive;
        negative = word_t'($urandom()) | 8'h80;
        positive = (word_t'($urandom()) & 8'h7F) | 8'h01;
        run_jump_program(negative);
        run_jump_program(8'h00);
        run_jump_program(positive);
    endtask

    task automatic test_nop_halt();
        begin_program();
        emit_single(OP_NOP);
        // Unused opcodes, low nibble ignored
        emit(8'h7C);
        emit(8'hB5);
        emit(8'hC0);
        emit(8'hD3);
        emit(8'hE9);
        emit_single(OP_HLT);
        // Past the HLT, never executed
        emit_op(OP_STA, AUX_ADDR);
        emit_op(OP_STA, RES_ADDR);
        for (int i = 0; i < 256; i++) begin
            expected_mem[i] = u_ram.mem[i];
        end
        run_program();
        repeat (50) begin
            @(negedge clk);
            check_equal("halted after HLT", 8'h01, word_t'(halted));
            check_equal("mem_write after HLT", 8'h00, word_t'(mem_write));
        end
        for (int i = 0; i < 256; i++) begin
            check_equal($sformatf("mem[%02h]", i), expected_mem[i], u_ram.mem[i]);
        end
    endtask

    initial begin
        seed = SEED;
        seed = $urandom(seed);
        reset = 1'b1;
        test_load_store();
        test_reset_state();
        test_alu();
        test_jumps();
        test_nop_halt();
        $display("TEST PASSED");
        $finish;
    end

endmodule

// ==== sim/neander_ram.sv ====
`timescale 1ns/100ps

module neander_ram (
    input  logic               clk,
    input  neander_pkg::addr_t addr,
    input  neander_pkg::word_t write_data,
    input  logic               write_en,
    output neander_pkg::word_t read_data
);

    import neander_pkg::*;

    // Preloaded directly by the testbench
    word_t mem [0:255];

    // Read is combinational so the CPU sees data in the same cycle
    assign read_data = mem[addr];

    always @(posedge clk) begin
        if (write_en) begin
            mem[addr] <= write_data;
        end
    end

endmodule
